// File: logic/isaPkg.sv
package isaPkg;

	// Native view of a head halfword
	typedef struct packed {
		logic [3:0] major;  // Opcode block
		logic [2:0] sub;    // Selects length within the block
		logic [8:0] rest;
	} nativeView_t;

	// RISC-V view, only the low two bits matter for length
	typedef struct packed {
		logic [13:0] rest;
		logic [1:0]  quadrant;  // 3 means a 32-bit op
	} rvView_t;

	typedef union packed {
		nativeView_t native;
		rvView_t     rv;
	} opWord_t;

	typedef enum logic [1:0] {
		len16 = 2'd0,
		len32 = 2'd1,
		len64 = 2'd2,  // WEX bundle or jumbo form
		len96 = 2'd3
	} opLen_t;

	typedef struct packed {
		logic xg2Mode;    // Wide encoding
		logic rvMode;     // RISC-V length rule
		logic wexEnable;  // 64-bit bundles allowed
	} fetchMode_t;

	// Halfwords occupied by an instruction of the given length
	function automatic logic [2:0] halfwordsOf(opLen_t len);
		case (len)
			len16:   return 3'd1;
			len32:   return 3'd2;
			len64:   return 3'd4;
			default: return 3'd6;
		endcase
	endfunction

endpackage

// File: logic/fetchPkg.sv
package fetchPkg;

	localparam int wordHalfwords = 4;  // Halfwords per memory word
	localparam int maxHalfwords = 6;   // Longest instruction, 96 bits

	// Word address toward memory, low three bits always zero
	typedef logic [31:0] memReq_t;

	// Halfword 0 in bits 15..0, first in the stream
	typedef logic [63:0] memResp_t;

	// Up to six halfwords, first one in the low bits
	typedef logic [16*maxHalfwords-1:0] instrBits_t;

	typedef logic [15:0] hwCount_t;  // Buffer space in halfwords

	// One whole instruction as handed to the consumer
	typedef struct packed {
		instrBits_t     bits;  // Unused halfwords are zero
		logic [31:0]    pc;    // Byte address of first halfword
		isaPkg::opLen_t len;
	} issuedInstr_t;

endpackage

// File: logic/instrLenDecode.sv
`timescale 1ns/1ps

module instrLenDecode (
	input  isaPkg::opWord_t    word,
	input  isaPkg::fetchMode_t mode,
	output isaPkg::opLen_t     opLen
);

	logic           wideClass;  // XG2, or the E/F blocks
	logic           pairMajor;  // Blocks 9 and 7 carry 32/64-bit ops
	isaPkg::opLen_t nativeLen;
	isaPkg::opLen_t wexLen;

	assign wideClass = mode.xg2Mode || (word.native.major[3:1] == 3'b111);
	assign pairMajor = (word.native.major == 4'b1001) || (word.native.major == 4'b0111);

	always_comb begin
		nativeLen = isaPkg::len16;
		if (wideClass) begin
			casez ({word.native.major[0], word.native.sub})
				4'b1_111: nativeLen = isaPkg::len96;  // FE/FF
				4'b1_110: nativeLen = isaPkg::len64;  // FC/FD
				4'b1_10?: nativeLen = isaPkg::len32;  // F8..FB
				4'b1_01?: nativeLen = isaPkg::len64;  // F4..F7
				4'b1_00?: nativeLen = isaPkg::len32;  // F0..F3
				4'b0_111: nativeLen = isaPkg::len64;
				4'b0_101: nativeLen = isaPkg::len64;  // EA/EB
				default:  nativeLen = isaPkg::len32;
			endcase
		end else if (pairMajor) begin
			nativeLen = word.native.sub[2] ? isaPkg::len64 : isaPkg::len32;
		end
	end

	// Without WEX a bundle goes out as two 32-bit ops
	assign wexLen = (!mode.wexEnable && nativeLen == isaPkg::len64) ?
		isaPkg::len32 : nativeLen;

	always_comb begin
		if (mode.rvMode) begin
			opLen = (word.rv.quadrant == 2'b11) ? isaPkg::len32 : isaPkg::len16;
		end else begin
			opLen = wexLen;
		end
	end

endmodule

// File: logic/fetchMemPort.sv
`timescale 1ns/1ps

module fetchMemPort #(
	parameter logic [31:0] resetAddr = 32'h0
) (
	input  logic               clock,
	input  logic               rst,
	input  fetchPkg::hwCount_t freeCount,
	output logic               memReqValid,
	output fetchPkg::memReq_t  memReq,
	input  logic               memAck,
	input  fetchPkg::memResp_t memResp,
	output logic               pushValid,
	output fetchPkg::memResp_t pushWord
);

	typedef enum logic [1:0] {
		stIdle,
		stRequest,    // req high, address held
		stWaitAckLow  // Word taken, waiting for ack to drop
	} portState_t;

	portState_t        state;
	fetchPkg::memReq_t nextAddr;  // Address of the next word to fetch
	logic              roomForWord;

	// Only pops happen while a request is out, so this room is still there on return
	assign roomForWord = freeCount >= fetchPkg::hwCount_t'(fetchPkg::wordHalfwords);

	assign memReqValid = (state == stRequest);
	assign memReq = nextAddr;

	// Word lands in the buffer on the edge that sees ack
	assign pushValid = (state == stRequest) && memAck;
	assign pushWord = memResp;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= stIdle;
			nextAddr <= resetAddr;
		end else begin
			case (state)
				stIdle: begin
					if (roomForWord)
						state <= stRequest;
				end
				stRequest: begin
					if (memAck) begin
						state <= stWaitAckLow;
						nextAddr <= nextAddr + 32'd8;  // Sequential words
					end
				end
				stWaitAckLow: begin
					if (!memAck)
						state <= roomForWord ? stRequest : stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

// File: logic/fetchBuffer.sv
`timescale 1ns/1ps

module fetchBuffer #(
	parameter logic [31:0] resetAddr = 32'h0,
	parameter int          bufHalfwords = 16
) (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 pushValid,
	input  fetchPkg::memResp_t   pushWord,
	input  logic                 popValid,
	input  logic [2:0]           popCount,
	output fetchPkg::instrBits_t headBits,
	output logic [2:0]           headCount,
	output fetchPkg::hwCount_t   freeCount,
	output logic [31:0]          headPc
);

	localparam int ptrBits = $clog2(bufHalfwords);
	localparam int cntBits = ptrBits + 1;  // Holds a full count

	logic [15:0]        store [bufHalfwords];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [cntBits-1:0] occupancy;
	logic [cntBits-1:0] pushAmount;
	logic [cntBits-1:0] popAmount;

	assign pushAmount = pushValid ? cntBits'(fetchPkg::wordHalfwords) : '0;
	assign popAmount = popValid ? cntBits'(popCount) : '0;

	// Four halfwords per word, pointer wraps on its own width
	always_ff @(posedge clock) begin
		if (pushValid) begin
			for (int i = 0; i < fetchPkg::wordHalfwords; i++) begin
				store[wrPtr + ptrBits'(i)] <= pushWord[16*i +: 16];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			occupancy <= '0;
			headPc <= resetAddr;
		end else begin
			if (pushValid)
				wrPtr <= wrPtr + ptrBits'(fetchPkg::wordHalfwords);
			if (popValid) begin
				rdPtr <= rdPtr + ptrBits'(popCount);
				headPc <= headPc + {28'd0, popCount, 1'b0};  // Two bytes per halfword
			end
			occupancy <= occupancy + pushAmount - popAmount;
		end
	end

	// Window of six halfwords at the head, stale past headCount
	always_comb begin
		for (int i = 0; i < fetchPkg::maxHalfwords; i++) begin
			headBits[16*i +: 16] = store[rdPtr + ptrBits'(i)];
		end
	end

	assign headCount = (occupancy >= cntBits'(fetchPkg::maxHalfwords)) ?
		3'(fetchPkg::maxHalfwords) : occupancy[2:0];

	assign freeCount = fetchPkg::hwCount_t'(bufHalfwords) - fetchPkg::hwCount_t'(occupancy);

endmodule

// File: logic/instrAligner.sv
`timescale 1ns/1ps

module instrAligner (
	input  logic                   clock,
	input  logic                   rst,
	input  isaPkg::fetchMode_t     mode,
	input  fetchPkg::instrBits_t   headBits,
	input  logic [2:0]             headCount,
	input  logic [31:0]            headPc,
	output logic                   popValid,
	output logic [2:0]             popCount,
	output logic                   outValid,
	output fetchPkg::issuedInstr_t outInstr,
	input  logic                   outReady
);

	isaPkg::opWord_t      headWord;
	isaPkg::opLen_t       headLen;
	logic [2:0]           needCount;  // Halfwords in the head instruction
	logic                 canLoad;
	logic                 loadNow;
	fetchPkg::instrBits_t keepMask;

	assign headWord = headBits[15:0];

	instrLenDecode lenDec0 (
		.word  (headWord),
		.mode  (mode),
		.opLen (headLen)
	);

	assign needCount = isaPkg::halfwordsOf(headLen);

	// Output register empty, or emptied this clock
	assign canLoad = !outValid || outReady;
	assign loadNow = canLoad && (headCount >= needCount);

	assign popValid = loadNow;
	assign popCount = needCount;

	always_comb begin
		for (int i = 0; i < fetchPkg::maxHalfwords; i++) begin
			keepMask[16*i +: 16] = (i < int'(needCount)) ? 16'hFFFF : 16'h0000;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (loadNow) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;  // Accepted, nothing new behind it
		end
	end

	// Payload only moves on load, so it holds during a stall
	always_ff @(posedge clock) begin
		if (loadNow) begin
			outInstr.bits <= headBits & keepMask;
			outInstr.pc <= headPc;
			outInstr.len <= headLen;
		end
	end

endmodule

// File: logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
	parameter logic [31:0] resetAddr = 32'h0,  // 8-byte aligned
	parameter int          bufHalfwords = 16   // Power of two, at least 8
) (
	input  logic                   clock,
	input  logic                   rst,
	input  isaPkg::fetchMode_t     mode,
	output logic                   memReqValid,
	output fetchPkg::memReq_t      memReq,
	input  logic                   memAck,
	input  fetchPkg::memResp_t     memResp,
	output logic                   outValid,
	output fetchPkg::issuedInstr_t outInstr,
	input  logic                   outReady
);

	fetchPkg::hwCount_t   freeCount;
	logic                 pushValid;
	fetchPkg::memResp_t   pushWord;
	logic                 popValid;
	logic [2:0]           popCount;
	fetchPkg::instrBits_t headBits;
	logic [2:0]           headCount;
	logic [31:0]          headPc;

	fetchMemPort #(
		.resetAddr (resetAddr)
	) memPort0 (
		.clock       (clock),
		.rst         (rst),
		.freeCount   (freeCount),
		.memReqValid (memReqValid),
		.memReq      (memReq),
		.memAck      (memAck),
		.memResp     (memResp),
		.pushValid   (pushValid),
		.pushWord    (pushWord)
	);

	fetchBuffer #(
		.resetAddr    (resetAddr),
		.bufHalfwords (bufHalfwords)
	) buf0 (
		.clock     (clock),
		.rst       (rst),
		.pushValid (pushValid),
		.pushWord  (pushWord),
		.popValid  (popValid),
		.popCount  (popCount),
		.headBits  (headBits),
		.headCount (headCount),
		.freeCount (freeCount),
		.headPc    (headPc)
	);

	instrAligner align0 (
		.clock     (clock),
		.rst       (rst),
		.mode      (mode),
		.headBits  (headBits),
		.headCount (headCount),
		.headPc    (headPc),
		.popValid  (popValid),
		.popCount  (popCount),
		.outValid  (outValid),
		.outInstr  (outInstr),
		.outReady  (outReady)
	);

endmodule

// File: bench/instrMemModel.sv
`timescale 1ns/1ps

module instrMemModel (
	input  logic               clock,
	input  logic               rst,
	input  logic               memReqValid,
	input  fetchPkg::memReq_t  memReq,
	output logic               memAck,
	output fetchPkg::memResp_t memResp
);

	logic               ackReg = 1'b0;
	fetchPkg::memResp_t dataReg = '0;
	logic [31:0]        rngState = 32'd49;  // Drives the ack delay only
	logic [2:0]         delayLeft = 3'd0;

	function automatic logic [31:0] lcgNext(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Content depends only on the word address
	function automatic logic [63:0] wordAt(logic [31:0] addr);
		logic [31:0] s;
		logic [63:0] w;
		s = 32'd49 ^ addr;
		for (int i = 0; i < 4; i++) begin
			s = lcgNext(s);
			w[16*i +: 16] = s[31:16];
		end
		return w;
	endfunction

	assign memAck = ackReg;
	assign memResp = dataReg;

	always @(posedge clock) begin
		if (rst) begin
			ackReg <= 1'b0;
			delayLeft <= 3'd0;
		end else if (!ackReg && memReqValid) begin
			if (delayLeft == 3'd0) begin
				ackReg <= 1'b1;  // Data valid with ack
				dataReg <= wordAt(memReq);
			end else begin
				delayLeft <= delayLeft - 3'd1;
			end
		end else if (ackReg && !memReqValid) begin
			ackReg <= 1'b0;
			rngState = lcgNext(rngState);
			delayLeft <= 3'(rngState[31:16] % 16'd6);  // 0 to 5 clocks
		end
	end

endmodule

// File: bench/fetchUnitTb.sv
`timescale 1ns/1ps

module fetchUnitTb;

	localparam logic [31:0] startAddr = 32'h0000_1000;
	localparam int          bufDepth = 16;
	localparam int          instrPerRun = 200;
	localparam int          runTimeout = 20000;  // Clocks per mode run

	localparam isaPkg::fetchMode_t baseCfg = '{xg2Mode: 1'b0, rvMode: 1'b0, wexEnable: 1'b1};
	localparam isaPkg::fetchMode_t wideCfg = '{xg2Mode: 1'b1, rvMode: 1'b0, wexEnable: 1'b1};
	localparam isaPkg::fetchMode_t rvCfg = '{xg2Mode: 1'b0, rvMode: 1'b1, wexEnable: 1'b1};
	localparam isaPkg::fetchMode_t noWexCfg = '{xg2Mode: 1'b0, rvMode: 1'b0, wexEnable: 1'b0};

	logic                   clock;
	logic                   rst = 1'b1;
	isaPkg::fetchMode_t     mode = baseCfg;
	logic                   outReady = 1'b0;
	logic                   memReqValid;
	fetchPkg::memReq_t      memReq;
	logic                   memAck;
	fetchPkg::memResp_t     memResp;
	logic                   outValid;
	fetchPkg::issuedInstr_t outInstr;

	logic [31:0]            walkPc;  // Reference walker position
	int                     acceptCount = 0;
	fetchPkg::issuedInstr_t wantInstr;
	fetchPkg::issuedInstr_t heldInstr;
	logic                   heldValid;
	logic [31:0]            nextReqAddr;
	logic                   reqPrev;
	logic                   ackPrev;
	fetchPkg::memReq_t      addrPrev;
	logic                   rstPrev;
	logic [31:0]            rngState = 32'd49;
	int                     stallLeft = 0;

	fetchUnit #(
		.resetAddr    (startAddr),
		.bufHalfwords (bufDepth)
	) dut0 (
		.clock       (clock),
		.rst         (rst),
		.mode        (mode),
		.memReqValid (memReqValid),
		.memReq      (memReq),
		.memAck      (memAck),
		.memResp     (memResp),
		.outValid    (outValid),
		.outInstr    (outInstr),
		.outReady    (outReady)
	);

	instrMemModel mem0 (
		.clock       (clock),
		.rst         (rst),
		.memReqValid (memReqValid),
		.memReq      (memReq),
		.memAck      (memAck),
		.memResp     (memResp)
	);

	function automatic logic [31:0] lcgNext(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Same content rule as the memory model
	function automatic logic [63:0] wordAt(logic [31:0] addr);
		logic [31:0] s;
		logic [63:0] w;
		s = 32'd49 ^ addr;
		for (int i = 0; i < 4; i++) begin
			s = lcgNext(s);
			w[16*i +: 16] = s[31:16];
		end
		return w;
	endfunction

	function automatic logic [15:0] halfwordAt(logic [31:0] addr);
		logic [63:0] w;
		w = wordAt({addr[31:3], 3'b000});
		return w[16*addr[2:1] +: 16];
	endfunction

	function automatic isaPkg::opLen_t lengthRule(logic [15:0] hw, isaPkg::fetchMode_t m);
		logic [3:0]     major;
		logic [2:0]     sub;
		isaPkg::opLen_t len;
		major = hw[15:12];
		sub = hw[11:9];
		if (m.rvMode)
			return (hw[1:0] == 2'b11) ? isaPkg::len32 : isaPkg::len16;
		if (m.xg2Mode || major == 4'hE || major == 4'hF) begin
			if (major[0])
				len = (sub == 3'b111) ? isaPkg::len96 :
					(sub == 3'b110 || sub[2:1] == 2'b01) ? isaPkg::len64 : isaPkg::len32;
			else
				len = (sub == 3'b111 || sub == 3'b101) ? isaPkg::len64 : isaPkg::len32;
		end else if (major == 4'h9 || major == 4'h7) begin
			len = sub[2] ? isaPkg::len64 : isaPkg::len32;
		end else begin
			len = isaPkg::len16;
		end
		if (!m.wexEnable && len == isaPkg::len64)
			len = isaPkg::len32;  // Bundle splits in two
		return len;
	endfunction

	function automatic int lenHalfwords(isaPkg::opLen_t len);
		return (len == isaPkg::len16) ? 1 : (len == isaPkg::len32) ? 2 :
			(len == isaPkg::len64) ? 4 : 6;
	endfunction

	function automatic fetchPkg::issuedInstr_t refInstr(logic [31:0] pc, isaPkg::fetchMode_t m);
		fetchPkg::issuedInstr_t r;
		r.pc = pc;
		r.len = lengthRule(halfwordAt(pc), m);
		r.bits = '0;
		for (int i = 0; i < lenHalfwords(r.len); i++)
			r.bits[16*i +: 16] = halfwordAt(pc + 32'(2 * i));
		return r;
	endfunction

	task automatic reportMismatch(input string name, input logic [127:0] got,
		input logic [127:0] want);
		$display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, want);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic reportProblem(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic compareInstr(input string name, input fetchPkg::issuedInstr_t got,
		input fetchPkg::issuedInstr_t want);
		assert (got.pc == want.pc) else reportMismatch({name, ".pc"}, 128'(got.pc), 128'(want.pc));
		assert (got.len == want.len)
			else reportMismatch({name, ".len"}, 128'(got.len), 128'(want.len));
		assert (got.bits == want.bits)
			else reportMismatch({name, ".bits"}, 128'(got.bits), 128'(want.bits));
	endtask

	task automatic checkIdle();
		assert (!outValid) else reportMismatch("outValid", 128'(outValid), 128'(0));
		assert (!memReqValid) else reportMismatch("memReqValid", 128'(memReqValid), 128'(0));
	endtask

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Random ready with occasional long stalls so the buffer fills
	always @(posedge clock) begin
		rngState = lcgNext(rngState);
		if (stallLeft > 0) begin
			stallLeft = stallLeft - 1;
			outReady <= 1'b0;
		end else if (rngState[31:27] == 5'd0) begin
			stallLeft = int'(rngState[20:16]);
			outReady <= 1'b0;
		end else begin
			outReady <= (rngState[26:25] != 2'b00);
		end
	end

	// Monitor samples at the falling edge where everything is settled
	always @(negedge clock) begin
		if (rstPrev)
			checkIdle();  // Reset was seen on the last rising edge
		if (rst) begin
			walkPc = startAddr;
			acceptCount = 0;
			heldValid = 1'b0;
			nextReqAddr = startAddr;
		end else begin
			if (memReqValid && !reqPrev) begin
				assert (!ackPrev) else reportProblem("memory request raised while ack was high");
				assert (memReq == nextReqAddr)
					else reportMismatch("memReq", 128'(memReq), 128'(nextReqAddr));
				nextReqAddr = nextReqAddr + 32'd8;
			end
			if (memReqValid && reqPrev)
				assert (memReq == addrPrev)
					else reportMismatch("memReq", 128'(memReq), 128'(addrPrev));
			if (heldValid) begin
				assert (outValid) else reportProblem("outValid dropped while stalled");
				compareInstr("outInstr", outInstr, heldInstr);
			end
			if (outValid && outReady) begin
				assert (mode.wexEnable || outInstr.len != isaPkg::len64)
					else reportProblem("64-bit instruction issued with WEX off");
				wantInstr = refInstr(walkPc, mode);
				compareInstr("outInstr", outInstr, wantInstr);
				walkPc = walkPc + 32'(2 * lenHalfwords(wantInstr.len));
				acceptCount++;
			end
			heldValid = outValid && !outReady;
			heldInstr = outInstr;
		end
		rstPrev = rst;
		reqPrev = memReqValid;
		ackPrev = memAck;
		addrPrev = memReq;
	end

	task automatic runMode(input isaPkg::fetchMode_t m, input string name);
		int waited;
		waited = 0;
		@(posedge clock);
		rst <= 1'b1;
		mode <= m;
		repeat (8) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		while (acceptCount < instrPerRun) begin
			@(posedge clock);
			waited++;
			if (waited > runTimeout)
				reportProblem($sformatf("timeout in %s run after %0d instructions",
					name, acceptCount));
		end
		$display("Run %s: %0d instructions checked", name, acceptCount);
	endtask

	initial begin
		runMode(baseCfg, "base");
		runMode(wideCfg, "XG2");
		runMode(rvCfg, "RISC-V");
		runMode(noWexCfg, "base without WEX");
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: flist.f
logic/isaPkg.sv
logic/fetchPkg.sv
logic/instrLenDecode.sv
logic/fetchMemPort.sv
logic/fetchBuffer.sv
logic/instrAligner.sv
logic/fetchUnit.sv
bench/instrMemModel.sv
bench/fetchUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetchUnitTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_TEXT ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
